/* design/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Architectural registers with XZR at index 31
`define GPR_COUNT 32
`define GPR_IDX_SIZE 5

// Datapath
`define DATA_SIZE 32
`define IMM_SIZE 12

// Reorder buffer depth and its index width
`define ROB_COUNT 8
`define ROB_IDX_SIZE 3

// Multiplier pipeline depth
`define MUL_STAGES 3

`endif

/* design/isa_pkg.sv */
package isa_pkg;

  // Operation carried from decode down to the execution units
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    ORR = 3'd3,
    MOV = 3'd4,
    MUL = 3'd5
  } fu_op_t;

  // Meaning of a source field
  typedef enum logic [1:0] {
    REG_USED         = 2'd0,
    REG_IS_XZR       = 2'd1,
    REG_IS_IMMEDIATE = 2'd2,
    REG_IS_UNUSED    = 2'd3
  } reg_status_t;

endpackage

/* design/uarch_pkg.sv */
package uarch_pkg;

  // Life cycle of one reorder-buffer entry
  typedef enum logic [1:0] {
    EMPTY   = 2'd0,
    WAITING = 2'd1,
    ISSUED  = 2'd2,
    DONE    = 2'd3
  } rob_state_t;

  // Execution unit that owns an operation
  typedef enum logic {
    FU_ALU = 1'b0,
    FU_MUL = 1'b1
  } fu_t;

endpackage

/* design/reg_module.sv */
`timescale 1ns/100ps
`include "core_settings.svh"

module reg_module (
  input  logic                       in_clk,
  input  logic                       in_rst,
  // Decode
  input  logic                       dec_valid,
  input  isa_pkg::fu_op_t            dec_op,
  input  logic [`GPR_IDX_SIZE-1:0]   dec_dst,
  input  logic [`GPR_IDX_SIZE-1:0]   dec_src1,
  input  isa_pkg::reg_status_t       dec_src1_status,
  input  logic [`GPR_IDX_SIZE-1:0]   dec_src2,
  input  isa_pkg::reg_status_t       dec_src2_status,
  input  logic [`IMM_SIZE-1:0]       dec_imm,
  input  logic                       dec_set_nzcv,
  // Reorder buffer tail and commit
  input  logic [`ROB_IDX_SIZE-1:0]   next_rob_index,
  input  logic                       commit_valid,
  input  logic [`ROB_IDX_SIZE-1:0]   commit_rob_index,
  input  logic [`GPR_IDX_SIZE-1:0]   commit_reg,
  input  logic [`DATA_SIZE-1:0]      commit_value,
  // Dispatch
  output logic                       disp_valid,
  output isa_pkg::fu_op_t            disp_op,
  output logic [`GPR_IDX_SIZE-1:0]   disp_dst,
  output logic                       disp_set_nzcv,
  output logic                       src1_valid,
  output logic [`DATA_SIZE-1:0]      src1_value,
  output logic [`ROB_IDX_SIZE-1:0]   src1_rob_index,
  output logic                       src2_valid,
  output logic [`DATA_SIZE-1:0]      src2_value,
  output logic [`ROB_IDX_SIZE-1:0]   src2_rob_index
);

  localparam logic [`GPR_IDX_SIZE-1:0] XZR_IDX = `GPR_IDX_SIZE'(`GPR_COUNT - 1);

  // Register table
  logic [`DATA_SIZE-1:0]    gpr_value [`GPR_COUNT];
  logic [`GPR_COUNT-1:0]    gpr_valid;
  logic [`ROB_IDX_SIZE-1:0] gpr_tag   [`GPR_COUNT];

  // Buffered decode
  logic                     d_valid;
  isa_pkg::fu_op_t          d_op;
  logic [`GPR_IDX_SIZE-1:0] d_dst;
  logic [`GPR_IDX_SIZE-1:0] d_src1;
  isa_pkg::reg_status_t     d_src1_status;
  logic [`GPR_IDX_SIZE-1:0] d_src2;
  isa_pkg::reg_status_t     d_src2_status;
  logic [`IMM_SIZE-1:0]     d_imm;
  logic                     d_set_nzcv;

  logic [`DATA_SIZE:0]      src1_read;
  logic [`DATA_SIZE:0]      src2_read;

  // Returns {valid, value} for one source field
  function automatic logic [`DATA_SIZE:0] read_src(input logic [`GPR_IDX_SIZE-1:0] idx,
                                                   input isa_pkg::reg_status_t st);
    case (st)
      isa_pkg::REG_IS_XZR:       return {1'b1, {`DATA_SIZE{1'b0}}};
      isa_pkg::REG_IS_IMMEDIATE: return {1'b1, {(`DATA_SIZE-`IMM_SIZE){1'b0}}, d_imm};
      isa_pkg::REG_IS_UNUSED:    return {1'b1, gpr_value[idx]};
      default:                   return {gpr_valid[idx], gpr_value[idx]};
    endcase
  endfunction

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      d_valid <= 1'b0;
      for (int i = 0; i < `GPR_COUNT; i++) begin
        gpr_value[i] <= '0;
        gpr_valid[i] <= 1'b1;
        gpr_tag[i]   <= '0;
      end
    end else begin
      d_valid <= dec_valid;
      // Only the newest producer of a register may write it back
      if (commit_valid && commit_reg != XZR_IDX &&
          gpr_tag[commit_reg] == commit_rob_index) begin
        gpr_value[commit_reg] <= commit_value;
        gpr_valid[commit_reg] <= 1'b1;
      end
      // Rename lands after the commit so a same-cycle rename wins
      if (d_valid && d_dst != XZR_IDX) begin
        gpr_valid[d_dst] <= 1'b0;
        gpr_tag[d_dst]   <= next_rob_index;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (dec_valid) begin
      d_op          <= dec_op;
      d_dst         <= dec_dst;
      d_src1        <= dec_src1;
      d_src1_status <= dec_src1_status;
      d_src2        <= dec_src2;
      d_src2_status <= dec_src2_status;
      d_imm         <= dec_imm;
      d_set_nzcv    <= dec_set_nzcv;
    end
  end

  // Tags are read before this instruction's own rename lands, so src == dst
  // still sees the previous producer
  always_comb begin
    src1_read      = read_src(d_src1, d_src1_status);
    src2_read      = read_src(d_src2, d_src2_status);
    src1_valid     = src1_read[`DATA_SIZE];
    src1_value     = src1_read[`DATA_SIZE-1:0];
    src2_valid     = src2_read[`DATA_SIZE];
    src2_value     = src2_read[`DATA_SIZE-1:0];
    src1_rob_index = gpr_tag[d_src1];
    src2_rob_index = gpr_tag[d_src2];
  end

  assign disp_valid    = d_valid;
  assign disp_op       = d_op;
  assign disp_dst      = d_dst;
  assign disp_set_nzcv = d_set_nzcv;

endmodule

/* design/reorder_buffer.sv */
`timescale 1ns/100ps
`include "core_settings.svh"

module reorder_buffer (
  input  logic                       in_clk,
  input  logic                       in_rst,
  // Dispatch
  input  logic                       disp_valid,
  input  isa_pkg::fu_op_t            disp_op,
  input  logic [`GPR_IDX_SIZE-1:0]   disp_dst,
  input  logic                       disp_set_nzcv,
  input  logic                       src1_valid,
  input  logic [`DATA_SIZE-1:0]      src1_value,
  input  logic [`ROB_IDX_SIZE-1:0]   src1_rob_index,
  input  logic                       src2_valid,
  input  logic [`DATA_SIZE-1:0]      src2_value,
  input  logic [`ROB_IDX_SIZE-1:0]   src2_rob_index,
  // Units and result bus
  input  logic                       alu_busy,
  input  logic                       res_valid,
  input  logic [`ROB_IDX_SIZE-1:0]   res_tag,
  input  logic [`DATA_SIZE-1:0]      res_value,
  input  logic [3:0]                 res_nzcv,
  output logic [`ROB_IDX_SIZE-1:0]   next_rob_index,
  output logic                       rob_full,
  output logic                       alu_issue,
  output isa_pkg::fu_op_t            alu_op,
  output logic [`DATA_SIZE-1:0]      alu_a,
  output logic [`DATA_SIZE-1:0]      alu_b,
  output logic [`ROB_IDX_SIZE-1:0]   alu_tag,
  output logic                       alu_set_nzcv,
  output logic                       mul_issue,
  output logic [`DATA_SIZE-1:0]      mul_a,
  output logic [`DATA_SIZE-1:0]      mul_b,
  output logic [`ROB_IDX_SIZE-1:0]   mul_tag,
  // Commit
  output logic                       commit_valid,
  output logic [`ROB_IDX_SIZE-1:0]   commit_rob_index,
  output logic [`GPR_IDX_SIZE-1:0]   commit_reg,
  output logic [`DATA_SIZE-1:0]      commit_value,
  output logic                       commit_set_nzcv,
  output logic [3:0]                 commit_nzcv
);

  uarch_pkg::rob_state_t     state [`ROB_COUNT];
  isa_pkg::fu_op_t           op    [`ROB_COUNT];
  logic [`GPR_IDX_SIZE-1:0]  dst   [`ROB_COUNT];
  logic [`ROB_COUNT-1:0]     set_nzcv;
  logic [`ROB_COUNT-1:0]     a_rdy;
  logic [`ROB_COUNT-1:0]     b_rdy;
  logic [`DATA_SIZE-1:0]     a_val [`ROB_COUNT];
  logic [`DATA_SIZE-1:0]     b_val [`ROB_COUNT];
  logic [`ROB_IDX_SIZE-1:0]  a_tag [`ROB_COUNT];
  logic [`ROB_IDX_SIZE-1:0]  b_tag [`ROB_COUNT];
  logic [`DATA_SIZE-1:0]     value [`ROB_COUNT];
  logic [3:0]                nzcv  [`ROB_COUNT];
  logic [3:0]                arch_nzcv;

  logic [`ROB_IDX_SIZE-1:0]  head;
  logic [`ROB_IDX_SIZE-1:0]  tail;
  logic [`ROB_IDX_SIZE:0]    count;
  logic [`DATA_SIZE:0]       src1_res;
  logic [`DATA_SIZE:0]       src2_res;
  logic                      alu_found;
  logic                      mul_found;
  logic [`ROB_IDX_SIZE-1:0]  alu_idx;
  logic [`ROB_IDX_SIZE-1:0]  mul_idx;

  function automatic uarch_pkg::fu_t unit_of(input isa_pkg::fu_op_t o);
    return (o == isa_pkg::MUL) ? uarch_pkg::FU_MUL : uarch_pkg::FU_ALU;
  endfunction

  // Operand at dispatch from the register file, a finished producer or the bus
  function automatic logic [`DATA_SIZE:0] resolve(input logic vld,
                                                  input logic [`DATA_SIZE-1:0] val,
                                                  input logic [`ROB_IDX_SIZE-1:0] tag);
    if (vld)
      return {1'b1, val};
    if (state[tag] == uarch_pkg::DONE)
      return {1'b1, value[tag]};
    if (res_valid && res_tag == tag)
      return {1'b1, res_value};
    return {1'b0, val};
  endfunction

  // Oldest ready entry per unit scanning from the head
  always_comb begin
    logic [`ROB_IDX_SIZE-1:0] idx;
    alu_found = 1'b0;
    mul_found = 1'b0;
    alu_idx   = '0;
    mul_idx   = '0;
    for (int i = 0; i < `ROB_COUNT; i++) begin
      idx = head + i[`ROB_IDX_SIZE-1:0];
      if (state[idx] == uarch_pkg::WAITING && a_rdy[idx] && b_rdy[idx]) begin
        if (unit_of(op[idx]) == uarch_pkg::FU_ALU && !alu_found) begin
          alu_found = 1'b1;
          alu_idx   = idx;
        end else if (unit_of(op[idx]) == uarch_pkg::FU_MUL && !mul_found) begin
          mul_found = 1'b1;
          mul_idx   = idx;
        end
      end
    end
    src1_res = resolve(src1_valid, src1_value, src1_rob_index);
    src2_res = resolve(src2_valid, src2_value, src2_rob_index);
  end

  assign alu_issue    = alu_found && !alu_busy;
  assign alu_op       = op[alu_idx];
  assign alu_a        = a_val[alu_idx];
  assign alu_b        = b_val[alu_idx];
  assign alu_tag      = alu_idx;
  assign alu_set_nzcv = set_nzcv[alu_idx];
  assign mul_issue    = mul_found;
  assign mul_a        = a_val[mul_idx];
  assign mul_b        = b_val[mul_idx];
  assign mul_tag      = mul_idx;

  assign commit_valid     = (state[head] == uarch_pkg::DONE);
  assign commit_rob_index = head;
  assign commit_reg       = dst[head];
  assign commit_value     = value[head];
  assign commit_set_nzcv  = set_nzcv[head];
  assign commit_nzcv      = set_nzcv[head] ? nzcv[head] : arch_nzcv;

  assign next_rob_index = tail;
  // Count the dispatch already in flight from the register module
  assign rob_full = (count + {{`ROB_IDX_SIZE{1'b0}}, disp_valid}) >= `ROB_COUNT;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      arch_nzcv <= '0;
      for (int i = 0; i < `ROB_COUNT; i++)
        state[i] <= uarch_pkg::EMPTY;
    end else begin
      // Result capture and operand snoop
      if (res_valid) begin
        state[res_tag] <= uarch_pkg::DONE;
        value[res_tag] <= res_value;
        nzcv[res_tag]  <= res_nzcv;
        for (int i = 0; i < `ROB_COUNT; i++) begin
          if (state[i] == uarch_pkg::WAITING && !a_rdy[i] && a_tag[i] == res_tag) begin
            a_rdy[i] <= 1'b1;
            a_val[i] <= res_value;
          end
          if (state[i] == uarch_pkg::WAITING && !b_rdy[i] && b_tag[i] == res_tag) begin
            b_rdy[i] <= 1'b1;
            b_val[i] <= res_value;
          end
        end
      end
      if (alu_issue)
        state[alu_idx] <= uarch_pkg::ISSUED;
      if (mul_issue)
        state[mul_idx] <= uarch_pkg::ISSUED;
      // In-order retire
      if (commit_valid) begin
        state[head] <= uarch_pkg::EMPTY;
        head        <= head + 1'b1;
        if (set_nzcv[head])
          arch_nzcv <= nzcv[head];
      end
      if (disp_valid) begin
        state[tail]    <= uarch_pkg::WAITING;
        op[tail]       <= disp_op;
        dst[tail]      <= disp_dst;
        // Multiplies never write the flags
        set_nzcv[tail] <= disp_set_nzcv && disp_op != isa_pkg::MUL;
        a_rdy[tail]    <= src1_res[`DATA_SIZE];
        a_val[tail]    <= src1_res[`DATA_SIZE-1:0];
        a_tag[tail]    <= src1_rob_index;
        b_rdy[tail]    <= src2_res[`DATA_SIZE];
        b_val[tail]    <= src2_res[`DATA_SIZE-1:0];
        b_tag[tail]    <= src2_rob_index;
        tail           <= tail + 1'b1;
      end
      case ({disp_valid, commit_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

/* design/alu_unit.sv */
`timescale 1ns/100ps
`include "core_settings.svh"

module alu_unit (
  input  logic                       in_clk,
  input  logic                       in_rst,
  input  logic                       alu_issue,
  input  isa_pkg::fu_op_t            alu_op,
  input  logic [`DATA_SIZE-1:0]      alu_a,
  input  logic [`DATA_SIZE-1:0]      alu_b,
  input  logic [`ROB_IDX_SIZE-1:0]   alu_tag,
  input  logic                       alu_set_nzcv,
  input  logic                       alu_grant,
  output logic                       alu_res_valid,
  output logic [`DATA_SIZE-1:0]      alu_res_value,
  output logic [`ROB_IDX_SIZE-1:0]   alu_res_tag,
  output logic [3:0]                 alu_res_nzcv,
  output logic                       alu_busy
);

  logic [`DATA_SIZE:0]   sum;
  logic [`DATA_SIZE:0]   diff;
  logic [`DATA_SIZE-1:0] result;
  logic                  carry;
  logic                  ovf;
  logic [3:0]            flags;

  always_comb begin
    sum    = {1'b0, alu_a} + {1'b0, alu_b};
    diff   = {1'b0, alu_a} - {1'b0, alu_b};
    result = '0;
    carry  = 1'b0;
    ovf    = 1'b0;
    case (alu_op)
      isa_pkg::ADD: begin
        result = sum[`DATA_SIZE-1:0];
        carry  = sum[`DATA_SIZE];
        ovf    = (alu_a[`DATA_SIZE-1] == alu_b[`DATA_SIZE-1]) &&
                 (result[`DATA_SIZE-1] != alu_a[`DATA_SIZE-1]);
      end
      isa_pkg::SUB: begin
        result = diff[`DATA_SIZE-1:0];
        // C is set when no borrow occurs
        carry  = ~diff[`DATA_SIZE];
        ovf    = (alu_a[`DATA_SIZE-1] != alu_b[`DATA_SIZE-1]) &&
                 (result[`DATA_SIZE-1] != alu_a[`DATA_SIZE-1]);
      end
      isa_pkg::AND: result = alu_a & alu_b;
      isa_pkg::ORR: result = alu_a | alu_b;
      isa_pkg::MOV: result = alu_b;
      default:      result = '0;
    endcase
    flags = {result[`DATA_SIZE-1], result == '0, carry, ovf};
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      alu_res_valid <= 1'b0;
      alu_res_nzcv  <= '0;
    end else if (alu_issue) begin
      alu_res_valid <= 1'b1;
      if (alu_set_nzcv)
        alu_res_nzcv <= flags;
    end else if (alu_grant) begin
      alu_res_valid <= 1'b0;
    end
  end

  always_ff @(posedge in_clk) begin
    if (alu_issue) begin
      alu_res_value <= result;
      alu_res_tag   <= alu_tag;
    end
  end

  // Held result blocks the next issue until the bus takes it
  assign alu_busy = alu_res_valid && !alu_grant;

endmodule

/* design/mul_unit.sv */
`timescale 1ns/100ps
`include "core_settings.svh"

module mul_unit (
  input  logic                       in_clk,
  input  logic                       in_rst,
  input  logic                       mul_issue,
  input  logic [`DATA_SIZE-1:0]      mul_a,
  input  logic [`DATA_SIZE-1:0]      mul_b,
  input  logic [`ROB_IDX_SIZE-1:0]   mul_tag,
  output logic                       mul_res_valid,
  output logic [`DATA_SIZE-1:0]      mul_res_value,
  output logic [`ROB_IDX_SIZE-1:0]   mul_res_tag
);

  localparam int HALF = `DATA_SIZE / 2;

  logic [`MUL_STAGES-1:0]    vld;
  logic [`ROB_IDX_SIZE-1:0]  tag_pipe [`MUL_STAGES];
  logic [`DATA_SIZE-1:0]     pp_lo;
  logic [`DATA_SIZE-1:0]     pp_hi;
  logic [`DATA_SIZE-1:0]     prod [1:`MUL_STAGES-1];

  always_ff @(posedge in_clk) begin
    if (in_rst)
      vld <= '0;
    else
      vld <= {vld[`MUL_STAGES-2:0], mul_issue};
  end

  always_ff @(posedge in_clk) begin
    // Stage 0 splits the multiplier into two half-width partial products
    pp_lo       <= mul_a * mul_b[HALF-1:0];
    pp_hi       <= mul_a * mul_b[`DATA_SIZE-1:HALF];
    tag_pipe[0] <= mul_tag;
    // Stage 1 sums them into the low word of the product
    prod[1]     <= pp_lo + (pp_hi << HALF);
    for (int k = 1; k < `MUL_STAGES; k++)
      tag_pipe[k] <= tag_pipe[k-1];
    for (int k = 2; k < `MUL_STAGES; k++)
      prod[k] <= prod[k-1];
  end

  assign mul_res_valid = vld[`MUL_STAGES-1];
  assign mul_res_value = prod[`MUL_STAGES-1];
  assign mul_res_tag   = tag_pipe[`MUL_STAGES-1];

endmodule

/* design/result_arbiter.sv */
`timescale 1ns/100ps
`include "core_settings.svh"

module result_arbiter (
  input  logic                       alu_res_valid,
  input  logic [`DATA_SIZE-1:0]      alu_res_value,
  input  logic [`ROB_IDX_SIZE-1:0]   alu_res_tag,
  input  logic [3:0]                 alu_res_nzcv,
  input  logic                       mul_res_valid,
  input  logic [`DATA_SIZE-1:0]      mul_res_value,
  input  logic [`ROB_IDX_SIZE-1:0]   mul_res_tag,
  output logic                       alu_grant,
  output logic                       res_valid,
  output logic [`ROB_IDX_SIZE-1:0]   res_tag,
  output logic [`DATA_SIZE-1:0]      res_value,
  output logic [3:0]                 res_nzcv
);

  uarch_pkg::fu_t winner;

  // The multiplier cannot stall, so it always takes the bus
  assign winner    = mul_res_valid ? uarch_pkg::FU_MUL : uarch_pkg::FU_ALU;
  assign alu_grant = alu_res_valid && (winner == uarch_pkg::FU_ALU);
  assign res_valid = mul_res_valid || alu_res_valid;

  always_comb begin
    if (winner == uarch_pkg::FU_MUL) begin
      res_tag   = mul_res_tag;
      res_value = mul_res_value;
      res_nzcv  = 4'b0000;
    end else begin
      res_tag   = alu_res_tag;
      res_value = alu_res_value;
      res_nzcv  = alu_res_nzcv;
    end
  end

endmodule

/* design/ooo_core_top.sv */
`timescale 1ns/100ps
`include "core_settings.svh"

module ooo_core_top (
  input  logic                       in_clk,
  input  logic                       in_rst,
  input  logic                       dec_valid,
  input  isa_pkg::fu_op_t            dec_op,
  input  logic [`GPR_IDX_SIZE-1:0]   dec_dst,
  input  logic [`GPR_IDX_SIZE-1:0]   dec_src1,
  input  isa_pkg::reg_status_t       dec_src1_status,
  input  logic [`GPR_IDX_SIZE-1:0]   dec_src2,
  input  isa_pkg::reg_status_t       dec_src2_status,
  input  logic [`IMM_SIZE-1:0]       dec_imm,
  input  logic                       dec_set_nzcv,
  output logic                       rob_full,
  output logic                       commit_valid,
  output logic [`GPR_IDX_SIZE-1:0]   commit_reg,
  output logic [`DATA_SIZE-1:0]      commit_value,
  output logic                       commit_set_nzcv,
  output logic [3:0]                 commit_nzcv
);

  // Dispatch path
  logic                      disp_valid, disp_set_nzcv;
  isa_pkg::fu_op_t           disp_op;
  logic [`GPR_IDX_SIZE-1:0]  disp_dst;
  logic                      src1_valid, src2_valid;
  logic [`DATA_SIZE-1:0]     src1_value, src2_value;
  logic [`ROB_IDX_SIZE-1:0]  src1_rob_index, src2_rob_index;
  logic [`ROB_IDX_SIZE-1:0]  next_rob_index, commit_rob_index;

  // Issue path
  logic                      alu_issue, alu_set_nzcv, alu_busy, mul_issue;
  isa_pkg::fu_op_t           alu_op;
  logic [`DATA_SIZE-1:0]     alu_a, alu_b, mul_a, mul_b;
  logic [`ROB_IDX_SIZE-1:0]  alu_tag, mul_tag;

  // Result path
  logic                      alu_res_valid, mul_res_valid, alu_grant, res_valid;
  logic [`DATA_SIZE-1:0]     alu_res_value, mul_res_value, res_value;
  logic [`ROB_IDX_SIZE-1:0]  alu_res_tag, mul_res_tag, res_tag;
  logic [3:0]                alu_res_nzcv, res_nzcv;

  reg_module     u_reg (.*);
  reorder_buffer u_rob (.*);
  alu_unit       u_alu (.*);
  mul_unit       u_mul (.*);
  result_arbiter u_arb (.*);

endmodule

/* tests/ooo_core_checker.sv */
`timescale 1ns/100ps
`include "core_settings.svh"

module ooo_core_checker (
  input  logic                     in_clk,
  input  logic                     in_rst,
  input  logic                     dec_valid,
  input  isa_pkg::fu_op_t          dec_op,
  input  logic [`GPR_IDX_SIZE-1:0] dec_dst,
  input  logic [`GPR_IDX_SIZE-1:0] dec_src1,
  input  isa_pkg::reg_status_t     dec_src1_status,
  input  logic [`GPR_IDX_SIZE-1:0] dec_src2,
  input  isa_pkg::reg_status_t     dec_src2_status,
  input  logic [`IMM_SIZE-1:0]     dec_imm,
  input  logic                     dec_set_nzcv,
  input  logic                     commit_valid,
  input  logic [`GPR_IDX_SIZE-1:0] commit_reg,
  input  logic [`DATA_SIZE-1:0]    commit_value,
  input  logic                     commit_set_nzcv,
  input  logic [3:0]               commit_nzcv,
  output int                       mismatch_count,
  output int                       other_count,
  output int                       decode_count,
  output int                       commit_count
);

  localparam logic [`GPR_IDX_SIZE-1:0] XZR = `GPR_IDX_SIZE'(`GPR_COUNT - 1);
  localparam longint SMAX = (longint'(1) <<< (`DATA_SIZE - 1)) - 1;
  localparam longint SMIN = -(longint'(1) <<< (`DATA_SIZE - 1));

  // Architectural state updated in program order at decode
  logic [`DATA_SIZE-1:0]    arch_reg [`GPR_COUNT];
  logic [3:0]               arch_nzcv;

  // Expected commits in program order
  logic [`GPR_IDX_SIZE-1:0] exp_reg   [$];
  logic [`DATA_SIZE-1:0]    exp_value [$];
  logic                     exp_set   [$];
  logic [3:0]               exp_nzcv  [$];

  function automatic logic [`DATA_SIZE-1:0] source_value(
      input logic [`GPR_IDX_SIZE-1:0] idx,
      input isa_pkg::reg_status_t     st);
    case (st)
      isa_pkg::REG_IS_IMMEDIATE: return `DATA_SIZE'(dec_imm);
      isa_pkg::REG_USED:         return (idx == XZR) ? '0 : arch_reg[idx];
      default:                   return '0;
    endcase
  endfunction

  task automatic execute_decode();
    logic [`DATA_SIZE-1:0] a;
    logic [`DATA_SIZE-1:0] b;
    logic [`DATA_SIZE-1:0] res;
    longint                wide;
    logic                  c;
    logic                  v;
    logic                  sets;
    a    = source_value(dec_src1, dec_src1_status);
    b    = source_value(dec_src2, dec_src2_status);
    c    = 1'b0;
    v    = 1'b0;
    wide = 0;
    case (dec_op)
      isa_pkg::ADD: begin
        res  = a + b;
        // Unsigned wrap means a carry out
        c    = res < a;
        wide = longint'($signed(a)) + longint'($signed(b));
        v    = (wide > SMAX) || (wide < SMIN);
      end
      isa_pkg::SUB: begin
        res  = a - b;
        c    = a >= b;
        wide = longint'($signed(a)) - longint'($signed(b));
        v    = (wide > SMAX) || (wide < SMIN);
      end
      isa_pkg::AND: res = a & b;
      isa_pkg::ORR: res = a | b;
      isa_pkg::MOV: res = b;
      isa_pkg::MUL: res = a * b;
      default:      res = '0;
    endcase
    sets = dec_set_nzcv && (dec_op != isa_pkg::MUL);
    if (sets)
      arch_nzcv = {res[`DATA_SIZE-1], res == '0, c, v};
    if (dec_dst != XZR)
      arch_reg[dec_dst] = res;
    exp_reg.push_back(dec_dst);
    exp_value.push_back(res);
    exp_set.push_back(sets);
    exp_nzcv.push_back(arch_nzcv);
    decode_count++;
  endtask

  task automatic compare_field(input string name, input logic [`DATA_SIZE-1:0] got,
                               input logic [`DATA_SIZE-1:0] want);
    if (got !== want) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  task automatic check_commit();
    commit_count++;
    if (exp_reg.size() == 0) begin
      other_count++;
      $display("Error at %0t: a commit arrived with no decoded instruction left", $time);
    end else begin
      compare_field("commit_reg", `DATA_SIZE'(commit_reg), `DATA_SIZE'(exp_reg.pop_front()));
      compare_field("commit_value", commit_value, exp_value.pop_front());
      compare_field("commit_set_nzcv", `DATA_SIZE'(commit_set_nzcv),
                    `DATA_SIZE'(exp_set.pop_front()));
      compare_field("commit_nzcv", `DATA_SIZE'(commit_nzcv), `DATA_SIZE'(exp_nzcv.pop_front()));
    end
  endtask

  // Sample at the falling edge where DUT outputs and decode inputs are settled
  always @(negedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < `GPR_COUNT; i++)
        arch_reg[i] = '0;
      arch_nzcv      = '0;
      mismatch_count = 0;
      other_count    = 0;
      decode_count   = 0;
      commit_count   = 0;
      exp_reg.delete();
      exp_value.delete();
      exp_set.delete();
      exp_nzcv.delete();
    end else begin
      if (commit_valid)
        check_commit();
      if (dec_valid)
        execute_decode();
    end
  end

endmodule

/* tests/ooo_core_asserts.sv */
`timescale 1ns/100ps
`include "core_settings.svh"

module ooo_core_asserts (
  input logic                     in_clk,
  input logic                     in_rst,
  input logic                     dec_valid,
  input logic                     rob_full,
  input logic                     commit_valid,
  input logic                     alu_res_valid,
  input logic [`ROB_IDX_SIZE-1:0] alu_res_tag,
  input logic [`DATA_SIZE-1:0]    alu_res_value,
  input logic                     mul_res_valid
);

  // An ALU result that loses the bus to the multiplier stays put for the next cycle
  alu_holds_result: assert property (@(posedge in_clk) disable iff (in_rst)
    (alu_res_valid && mul_res_valid) |=>
      (alu_res_valid && $stable(alu_res_tag) && $stable(alu_res_value)))
    else $error("ALU result changed or dropped while the multiplier held the bus");

  no_decode_when_full: assert property (@(posedge in_clk) disable iff (in_rst)
    !(dec_valid && rob_full))
    else $error("Decode strobe while the reorder buffer is full");

  no_commit_in_reset: assert property (@(posedge in_clk) in_rst |-> !commit_valid)
    else $error("Commit strobe during reset");

endmodule

/* tests/ooo_core_tb.sv */
`timescale 1ns/100ps
`include "core_settings.svh"

module ooo_core_tb;

  localparam int NUM_INSTR      = 400;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 12;

  logic                     in_clk;
  logic                     in_rst;
  logic                     dec_valid;
  isa_pkg::fu_op_t          dec_op;
  logic [`GPR_IDX_SIZE-1:0] dec_dst;
  logic [`GPR_IDX_SIZE-1:0] dec_src1;
  isa_pkg::reg_status_t     dec_src1_status;
  logic [`GPR_IDX_SIZE-1:0] dec_src2;
  isa_pkg::reg_status_t     dec_src2_status;
  logic [`IMM_SIZE-1:0]     dec_imm;
  logic                     dec_set_nzcv;
  logic                     rob_full;
  logic                     commit_valid;
  logic [`GPR_IDX_SIZE-1:0] commit_reg;
  logic [`DATA_SIZE-1:0]    commit_value;
  logic                     commit_set_nzcv;
  logic [3:0]               commit_nzcv;

  int                       mismatch_count;
  int                       other_count;
  int                       decode_count;
  int                       commit_count;
  int                       tb_errors = 0;
  int                       sent = 0;
  int                       cycle_count = 0;
  logic [15:0]              lfsr = 16'd30;

  ooo_core_top DUT (.*);

  ooo_core_checker u_checker (.*);

  bind ooo_core_top ooo_core_asserts u_asserts (
    .in_clk(in_clk), .in_rst(in_rst), .dec_valid(dec_valid), .rob_full(rob_full),
    .commit_valid(commit_valid), .alu_res_valid(alu_res_valid),
    .alu_res_tag(alu_res_tag), .alu_res_value(alu_res_value),
    .mul_res_valid(mul_res_valid)
  );

  // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Small register pool for frequent dependences with an occasional XZR
  function automatic logic [`GPR_IDX_SIZE-1:0] pick_reg();
    if (random_bits(3) == 0)
      return `GPR_IDX_SIZE'(`GPR_COUNT - 1);
    return `GPR_IDX_SIZE'(random_bits(2));
  endfunction

  task automatic drive_random_instr();
    logic [2:0] op_bits;
    logic [2:0] src2_pick;
    op_bits = 3'(random_bits(3));
    dec_op  = (op_bits >= 3'd5) ? isa_pkg::MUL : isa_pkg::fu_op_t'(op_bits);
    dec_dst  = pick_reg();
    dec_src1 = pick_reg();
    dec_src2 = pick_reg();
    if (dec_op == isa_pkg::MOV)
      dec_src1_status = isa_pkg::REG_IS_UNUSED;
    else if (random_bits(3) == 0)
      dec_src1_status = isa_pkg::REG_IS_XZR;
    else
      dec_src1_status = isa_pkg::REG_USED;
    src2_pick = 3'(random_bits(3));
    if (src2_pick < 3'd2)
      dec_src2_status = isa_pkg::REG_IS_IMMEDIATE;
    else if (src2_pick == 3'd2)
      dec_src2_status = isa_pkg::REG_IS_XZR;
    else
      dec_src2_status = isa_pkg::REG_USED;
    dec_imm      = `IMM_SIZE'(random_bits(`IMM_SIZE));
    dec_set_nzcv = 1'(random_bits(1));
    dec_valid    = 1'b1;
  endtask

  task automatic print_counts(input int extra);
    $display("Errors: %0d total, %0d mismatches, %0d other; %0d decoded, %0d committed",
             mismatch_count + other_count + tb_errors + extra, mismatch_count,
             other_count + tb_errors + extra, decode_count, commit_count);
  endtask

  initial begin
    in_clk = 1'b0;
    forever #10 in_clk = ~in_clk;
  end

  always @(posedge in_clk)
    cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout after %0d cycles, only %0d of %0d commits arrived",
             cycle_count, commit_count, NUM_INSTR);
    print_counts(1);
    $display("Something failed");
    $finish;
  end

  initial begin
    in_rst          = 1'b1;
    dec_valid       = 1'b0;
    dec_op          = isa_pkg::ADD;
    dec_dst         = '0;
    dec_src1        = '0;
    dec_src1_status = isa_pkg::REG_USED;
    dec_src2        = '0;
    dec_src2_status = isa_pkg::REG_USED;
    dec_imm         = '0;
    dec_set_nzcv    = 1'b0;
    repeat (5) @(posedge in_clk);
    #2 in_rst = 1'b0;

    // About 70 percent of the free cycles carry an instruction
    while (sent < NUM_INSTR) begin
      @(posedge in_clk);
      #2;
      dec_valid = 1'b0;
      if (!rob_full && random_bits(7) < 90) begin
        drive_random_instr();
        sent++;
      end
    end
    @(posedge in_clk);
    #2 dec_valid = 1'b0;

    while (commit_count < NUM_INSTR)
      @(posedge in_clk);
    // Idle time to catch any extra commit
    repeat (20) @(posedge in_clk);

    if (decode_count != NUM_INSTR) begin
      tb_errors++;
      $display("Checker saw %0d decodes, %0d were driven", decode_count, NUM_INSTR);
    end
    if (commit_count != decode_count) begin
      tb_errors++;
      $display("Commit count %0d differs from decode count %0d", commit_count, decode_count);
    end
    print_counts(0);
    if (mismatch_count + other_count + tb_errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+design
design/isa_pkg.sv
design/uarch_pkg.sv
design/reg_module.sv
design/reorder_buffer.sv
design/alu_unit.sv
design/mul_unit.sv
design/result_arbiter.sv
design/ooo_core_top.sv
tests/ooo_core_checker.sv
tests/ooo_core_asserts.sv
tests/ooo_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the out-of-order core testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module ooo_core_tb -o ooo_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ooo_core_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
